// File: include/quad_root_settings.svh
`ifndef QUAD_ROOT_SETTINGS_SVH
`define QUAD_ROOT_SETTINGS_SVH

// input samples b and c, one integer bit plus sign
`define QR_DIN_WIDTH 16
`define QR_DIN_POINT 14

// narrowed domain shared by the FIFO, the square root and the roots
`define QR_SQRT_WIDTH 10
`define QR_SQRT_POINT 8

// FIFO holds 2**QR_FIFO_ADDR entries
`define QR_FIFO_ADDR 3

`define QR_BANDS 4

// one root bit per iteration, two radicand bits consumed each time
`define QR_SQRT_ITER ((`QR_SQRT_WIDTH + `QR_SQRT_POINT) / 2)

`endif

// File: verilog/quad_root_pkg.sv
`include "quad_root_settings.svh"

package quad_root_pkg;

    // raw input sample
    typedef logic signed [`QR_DIN_WIDTH-1:0] din_t;

    // square of b and the full-width discriminant
    typedef logic signed [2*`QR_DIN_WIDTH-1:0] wide_t;

    // narrowed discriminant, narrowed b, square root and roots
    typedef logic signed [`QR_SQRT_WIDTH-1:0] sqrt_t;

    typedef logic [$clog2(`QR_BANDS)-1:0] band_t;

    // square-root controller
    typedef enum logic [1:0] {
        idle,
        run,
        done
    } sqrt_state_t;

endpackage

// File: verilog/fixed_point_cast.sv
module fixed_point_cast #(
    parameter int in_width  = 32,
    parameter int in_point  = 26,
    parameter int out_width = 10,
    parameter int out_point = 8
) (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic signed [in_width-1:0]  din,
    input  logic                        din_valid,
    output logic signed [out_width-1:0] dout,
    output logic                        dout_valid
);

    localparam int shift = in_point - out_point;
    localparam int keep_width = in_width - shift;

    // output range expressed at the width of the floored value
    localparam logic signed [keep_width-1:0] max_val =
        {{(keep_width - out_width + 1){1'b0}}, {(out_width - 1){1'b1}}};
    localparam logic signed [keep_width-1:0] min_val =
        {{(keep_width - out_width + 1){1'b1}}, {(out_width - 1){1'b0}}};

    logic signed [keep_width-1:0] floored;
    logic signed [out_width-1:0]  clipped;

    // dropping low bits of a two's complement word rounds toward minus infinity
    assign floored = din[in_width-1:shift];

    always_comb begin
        if (floored > max_val) begin
            clipped = max_val[out_width-1:0];
        end else if (floored < min_val) begin
            clipped = min_val[out_width-1:0];
        end else begin
            clipped = floored[out_width-1:0];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            dout_valid <= 1'b0;
        end else begin
            dout_valid <= din_valid;
        end
    end

    // value holds between strobes
    always_ff @(posedge clk) begin
        if (din_valid) begin
            dout <= clipped;
        end
    end

endmodule

// File: verilog/discriminant_stage.sv
`include "quad_root_settings.svh"

module discriminant_stage (
    input  logic                 clk,
    input  logic                 rst_n,
    input  quad_root_pkg::din_t  b,
    input  quad_root_pkg::din_t  c,
    input  logic                 din_valid,
    input  quad_root_pkg::band_t band_in,
    output quad_root_pkg::sqrt_t disc,
    output quad_root_pkg::sqrt_t b_narrow,
    output quad_root_pkg::band_t band,
    output logic                 disc_valid
);

    // b*b carries 2*point fraction bits, the shift by two makes room for 4c
    localparam int disc_point = 2 * `QR_DIN_POINT - 2;

    logic [3:0]            valid_sr;
    quad_root_pkg::din_t   b_dly [4];
    quad_root_pkg::band_t  band_dly [4];
    quad_root_pkg::din_t   c_r;
    quad_root_pkg::wide_t  prod_s2;
    quad_root_pkg::wide_t  prod_s3;
    quad_root_pkg::wide_t  c4_s2;
    quad_root_pkg::wide_t  c4_s3;
    quad_root_pkg::wide_t  diff;

    // strobe follows the data through stages 1 to 4
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_sr <= '0;
        end else begin
            valid_sr <= {valid_sr[2:0], din_valid};
        end
    end

    always_ff @(posedge clk) begin
        // stage 1, input register
        b_dly[0]    <= b;
        c_r         <= c;
        band_dly[0] <= band_in;

        // stages 2 and 3, squarer pipeline with 4c scaled to the discriminant point
        prod_s2 <= quad_root_pkg::wide_t'(b_dly[0]) * quad_root_pkg::wide_t'(b_dly[0]);
        c4_s2   <= quad_root_pkg::wide_t'(c_r) <<< `QR_DIN_POINT;
        prod_s3 <= prod_s2;
        c4_s3   <= c4_s2;

        // stage 4
        diff <= (prod_s3 >>> 2) - c4_s3;

        for (int i = 1; i < 4; i++) begin
            b_dly[i]    <= b_dly[i-1];
            band_dly[i] <= band_dly[i-1];
        end
    end

    // stage 5, both casts and the band tag leave together
    fixed_point_cast #(
        .in_width  (2 * `QR_DIN_WIDTH),
        .in_point  (disc_point),
        .out_width (`QR_SQRT_WIDTH),
        .out_point (`QR_SQRT_POINT)
    ) disc_cast_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .din        (diff),
        .din_valid  (valid_sr[3]),
        .dout       (disc),
        .dout_valid (disc_valid)
    );

    fixed_point_cast #(
        .in_width  (`QR_DIN_WIDTH),
        .in_point  (`QR_DIN_POINT),
        .out_width (`QR_SQRT_WIDTH),
        .out_point (`QR_SQRT_POINT)
    ) b_cast_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .din        (b_dly[3]),
        .din_valid  (valid_sr[3]),
        .dout       (b_narrow),
        .dout_valid ()
    );

    always_ff @(posedge clk) begin
        if (valid_sr[3]) begin
            band <= band_dly[3];
        end
    end

endmodule

// File: verilog/sample_fifo.sv
`include "quad_root_settings.svh"

module sample_fifo (
    input  logic                 clk,
    input  logic                 rst_n,
    input  quad_root_pkg::sqrt_t wdata_disc,
    input  quad_root_pkg::sqrt_t wdata_b,
    input  quad_root_pkg::band_t wdata_band,
    input  logic                 w_valid,
    output logic                 full,
    output logic                 empty,
    input  logic                 pop,
    output quad_root_pkg::sqrt_t rdata_disc,
    output quad_root_pkg::sqrt_t rdata_b,
    output quad_root_pkg::band_t rdata_band,
    output logic                 r_valid
);

    localparam int depth = 1 << `QR_FIFO_ADDR;

    quad_root_pkg::sqrt_t mem_disc [depth];
    quad_root_pkg::sqrt_t mem_b [depth];
    quad_root_pkg::band_t mem_band [depth];

    logic [`QR_FIFO_ADDR-1:0] wr_ptr;
    logic [`QR_FIFO_ADDR-1:0] rd_ptr;
    logic [`QR_FIFO_ADDR:0]   count;
    logic                     wr_en;
    logic                     rd_en;

    assign full  = (count == depth);
    assign empty = (count == 0);

    // a write into a full buffer is lost
    assign wr_en = w_valid & ~full;
    assign rd_en = pop & ~empty;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            count   <= '0;
            r_valid <= 1'b0;
        end else begin
            r_valid <= rd_en;
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (wr_en && !rd_en) begin
                count <= count + 1'b1;
            end else if (rd_en && !wr_en) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem_disc[wr_ptr] <= wdata_disc;
            mem_b[wr_ptr]    <= wdata_b;
            mem_band[wr_ptr] <= wdata_band;
        end
        if (rd_en) begin
            rdata_disc <= mem_disc[rd_ptr];
            rdata_b    <= mem_b[rd_ptr];
            rdata_band <= mem_band[rd_ptr];
        end
    end

endmodule

// File: verilog/iterative_sqrt.sv
`include "quad_root_settings.svh"

module iterative_sqrt (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 start,
    input  quad_root_pkg::sqrt_t din,
    output logic                 busy,
    output quad_root_pkg::sqrt_t dout,
    output logic                 dout_valid
);

    localparam int iter      = `QR_SQRT_ITER;
    localparam int rad_width = 2 * iter;
    // remainder never exceeds twice the partial root, plus two new bits
    localparam int rem_width = iter + 3;
    localparam int cnt_width = $clog2(iter);

    quad_root_pkg::sqrt_state_t state;

    logic [cnt_width-1:0] count;
    logic [rad_width-1:0] rad;
    logic [rem_width-1:0] rem;
    logic [iter-1:0]      root;
    logic [rem_width-1:0] rem_shift;
    logic [rem_width-1:0] trial;
    logic                 trial_ok;

    // bring down the next two radicand bits and try root*4 + 1
    assign rem_shift = {rem[rem_width-3:0], rad[rad_width-1 -: 2]};
    assign trial     = {{(rem_width - iter - 2){1'b0}}, root, 2'b01};
    assign trial_ok  = (rem_shift >= trial);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= quad_root_pkg::idle;
            count <= '0;
        end else begin
            case (state)
                quad_root_pkg::idle: begin
                    count <= '0;
                    if (start) begin
                        state <= quad_root_pkg::run;
                    end
                end
                quad_root_pkg::run: begin
                    count <= count + 1'b1;
                    if (count == cnt_width'(iter - 1)) begin
                        state <= quad_root_pkg::done;
                    end
                end
                default: begin
                    state <= quad_root_pkg::idle;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == quad_root_pkg::idle && start) begin
            // operand is scaled by 2**point so the root keeps the same point
            rad  <= {din, {(`QR_SQRT_POINT){1'b0}}};
            rem  <= '0;
            root <= '0;
        end else if (state == quad_root_pkg::run) begin
            rad <= rad << 2;
            if (trial_ok) begin
                rem  <= rem_shift - trial;
                root <= {root[iter-2:0], 1'b1};
            end else begin
                rem  <= rem_shift;
                root <= {root[iter-2:0], 1'b0};
            end
        end
    end

    assign busy       = (state != quad_root_pkg::idle);
    assign dout_valid = (state == quad_root_pkg::done);
    assign dout       = {{(`QR_SQRT_WIDTH - iter){1'b0}}, root};

endmodule

// File: verilog/root_engine.sv
`include "quad_root_settings.svh"

module root_engine (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 empty,
    output logic                 pop,
    input  logic                 r_valid,
    input  quad_root_pkg::sqrt_t disc,
    input  quad_root_pkg::sqrt_t b_narrow,
    input  quad_root_pkg::band_t band,
    output quad_root_pkg::sqrt_t x1,
    output quad_root_pkg::sqrt_t x2,
    output quad_root_pkg::band_t band_out,
    output logic                 dout_valid,
    output logic                 dout_error
);

    localparam int cnt_width = $clog2(`QR_SQRT_ITER + 1);
    // error path waits as long as the square root would have
    localparam logic [cnt_width-1:0] err_delay = `QR_SQRT_ITER;

    logic                           occupied;
    logic                           sqrt_start;
    logic                           sqrt_busy;
    logic                           sqrt_valid;
    quad_root_pkg::sqrt_t           sqrt_root;
    quad_root_pkg::sqrt_t           b_hold;
    quad_root_pkg::band_t           band_hold;
    logic                           err_run;
    logic [cnt_width-1:0]           err_cnt;
    logic                           err_finish;
    logic signed [`QR_SQRT_WIDTH:0] neg_b;
    logic signed [`QR_SQRT_WIDTH:0] root_ext;
    logic signed [`QR_SQRT_WIDTH:0] sum_plus;
    logic signed [`QR_SQRT_WIDTH:0] sum_minus;

    // one entry in flight at a time
    assign pop        = ~occupied & ~sqrt_busy & ~empty;
    assign sqrt_start = r_valid & ~disc[`QR_SQRT_WIDTH-1];
    assign err_finish = err_run & (err_cnt == '0);

    iterative_sqrt iterative_sqrt_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .start      (sqrt_start),
        .din        (disc),
        .busy       (sqrt_busy),
        .dout       (sqrt_root),
        .dout_valid (sqrt_valid)
    );

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            occupied   <= 1'b0;
            err_run    <= 1'b0;
            err_cnt    <= '0;
            dout_valid <= 1'b0;
            dout_error <= 1'b0;
        end else begin
            dout_valid <= sqrt_valid;
            dout_error <= err_finish;
            if (sqrt_valid || err_finish) begin
                occupied <= 1'b0;
            end else if (pop) begin
                occupied <= 1'b1;
            end
            if (r_valid && disc[`QR_SQRT_WIDTH-1]) begin
                err_run <= 1'b1;
                err_cnt <= err_delay;
            end else if (err_finish) begin
                err_run <= 1'b0;
            end else if (err_run) begin
                err_cnt <= err_cnt - 1'b1;
            end
        end
    end

    // widen by one bit so -b +/- s cannot overflow before the halving
    assign neg_b     = -$signed({b_hold[`QR_SQRT_WIDTH-1], b_hold});
    assign root_ext  = {1'b0, sqrt_root};
    assign sum_plus  = neg_b + root_ext;
    assign sum_minus = neg_b - root_ext;

    always_ff @(posedge clk) begin
        if (r_valid) begin
            b_hold    <= b_narrow;
            band_hold <= band;
        end
        // dropping bit 0 halves with floor rounding
        if (sqrt_valid) begin
            x1 <= sum_plus[`QR_SQRT_WIDTH:1];
            x2 <= sum_minus[`QR_SQRT_WIDTH:1];
        end
        if (sqrt_valid || err_finish) begin
            band_out <= band_hold;
        end
    end

endmodule

// File: verilog/quad_root_iterative.sv
module quad_root_iterative (
    input  logic                 clk,
    input  logic                 rst_n,
    input  quad_root_pkg::din_t  b,
    input  quad_root_pkg::din_t  c,
    input  logic                 din_valid,
    input  quad_root_pkg::band_t band_in,
    output logic                 fifo_full,
    output quad_root_pkg::sqrt_t x1,
    output quad_root_pkg::sqrt_t x2,
    output logic                 dout_valid,
    output logic                 dout_error,
    output quad_root_pkg::band_t band_out
);

    quad_root_pkg::sqrt_t disc;
    quad_root_pkg::sqrt_t b_narrow;
    quad_root_pkg::band_t disc_band;
    logic                 disc_valid;

    logic                 fifo_empty;
    logic                 fifo_pop;
    quad_root_pkg::sqrt_t fifo_disc;
    quad_root_pkg::sqrt_t fifo_b;
    quad_root_pkg::band_t fifo_band;
    logic                 fifo_r_valid;

    // fixed 5 cycle front end
    discriminant_stage discriminant_stage_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .b          (b),
        .c          (c),
        .din_valid  (din_valid),
        .band_in    (band_in),
        .disc       (disc),
        .b_narrow   (b_narrow),
        .band       (disc_band),
        .disc_valid (disc_valid)
    );

    // absorbs samples while the square root is busy
    sample_fifo sample_fifo_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .wdata_disc (disc),
        .wdata_b    (b_narrow),
        .wdata_band (disc_band),
        .w_valid    (disc_valid),
        .full       (fifo_full),
        .empty      (fifo_empty),
        .pop        (fifo_pop),
        .rdata_disc (fifo_disc),
        .rdata_b    (fifo_b),
        .rdata_band (fifo_band),
        .r_valid    (fifo_r_valid)
    );

    root_engine root_engine_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .empty      (fifo_empty),
        .pop        (fifo_pop),
        .r_valid    (fifo_r_valid),
        .disc       (fifo_disc),
        .b_narrow   (fifo_b),
        .band       (fifo_band),
        .x1         (x1),
        .x2         (x2),
        .band_out   (band_out),
        .dout_valid (dout_valid),
        .dout_error (dout_error)
    );

endmodule

// File: sim/quad_root_checker.sv
module quad_root_checker (
    input logic clk,
    input logic rst_n,
    input logic fifo_full,
    input logic fifo_write,
    input logic dout_valid,
    input logic dout_error,
    input logic sqrt_start,
    input logic sqrt_busy
);

    timeunit 1ns;
    timeprecision 100ps;

    // number of assertion failures so far
    int assert_failures = 0;

    // a sample leaves as either roots or an error, never both
    one_strobe: assert property (@(posedge clk) disable iff (!rst_n)
        !(dout_valid && dout_error))
        else begin
            $error("dout_valid and dout_error high in the same cycle");
            assert_failures++;
        end

    // the source must hold back before the FIFO overflows
    no_write_when_full: assert property (@(posedge clk) disable iff (!rst_n)
        !(fifo_write && fifo_full))
        else begin
            $error("FIFO write while full");
            assert_failures++;
        end

    no_restart: assert property (@(posedge clk) disable iff (!rst_n)
        !(sqrt_start && sqrt_busy))
        else begin
            $error("square root started while busy");
            assert_failures++;
        end

    // one reset edge is enough to clear every strobe
    quiet_in_reset: assert property (@(posedge clk)
        (!rst_n ##1 !rst_n) |-> !(fifo_full || dout_valid || dout_error || sqrt_busy))
        else begin
            $error("output high during reset");
            assert_failures++;
        end

endmodule

// File: sim/quad_root_tb.sv
`include "quad_root_settings.svh"

module quad_root_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int num_fixed = 7;
    localparam int num_burst = 12;
    localparam int num_random = 60;
    localparam int num_rows = num_fixed + num_burst + num_random;
    // a sample still in the discriminant stage needs a free FIFO entry when it lands
    localparam int max_in_flight = (1 << `QR_FIFO_ADDR) + 1;
    localparam longint sat_max = (1 << (`QR_SQRT_WIDTH - 1)) - 1;
    localparam longint sat_min = -(1 << (`QR_SQRT_WIDTH - 1));

    logic                 clk = 1'b0;
    logic                 rst_n;
    quad_root_pkg::din_t  b;
    quad_root_pkg::din_t  c;
    logic                 din_valid;
    quad_root_pkg::band_t band_in;
    logic                 fifo_full;
    quad_root_pkg::sqrt_t x1;
    quad_root_pkg::sqrt_t x2;
    logic                 dout_valid;
    logic                 dout_error;
    quad_root_pkg::band_t band_out;

    // stimulus and expected results, one entry per row
    quad_root_pkg::din_t  row_b [num_rows];
    quad_root_pkg::din_t  row_c [num_rows];
    quad_root_pkg::band_t row_band [num_rows];
    int                   row_gap [num_rows];
    logic                 exp_error [num_rows];
    quad_root_pkg::sqrt_t exp_x1 [num_rows];
    quad_root_pkg::sqrt_t exp_x2 [num_rows];

    // roots of the last good row, held by the DUT across error strobes
    quad_root_pkg::sqrt_t last_x1;
    quad_root_pkg::sqrt_t last_x2;
    logic                 have_last;

    int          expect_q [$];
    int          rows_filled;
    int          total_gap;
    int          sent;
    int          results;
    int          errors;
    int          checks;
    int          cycles = 0;
    int          timeout_limit = 1000000;
    logic        saw_full;
    logic [31:0] lfsr_state;

    always #50 clk = ~clk;

    quad_root_iterative quad_root_iterative_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .b          (b),
        .c          (c),
        .din_valid  (din_valid),
        .band_in    (band_in),
        .fifo_full  (fifo_full),
        .x1         (x1),
        .x2         (x2),
        .dout_valid (dout_valid),
        .dout_error (dout_error),
        .band_out   (band_out)
    );

    bind quad_root_iterative quad_root_checker checker_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .fifo_full  (fifo_full),
        .fifo_write (disc_valid),
        .dout_valid (dout_valid),
        .dout_error (dout_error),
        .sqrt_start (root_engine_inst.sqrt_start),
        .sqrt_busy  (root_engine_inst.sqrt_busy)
    );

    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        logic [31:0] shifted;
        shifted = state >> 1;
        if (state[0]) begin
            shifted = shifted ^ 32'h8020_0003;
        end
        return shifted;
    endfunction

    task automatic random_bits(input int width, output logic [31:0] value);
        value = '0;
        for (int i = 0; i < width; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            value = {value[30:0], lfsr_state[0]};
        end
    endtask

    function automatic longint isqrt(input longint n);
        longint r;
        r = 0;
        while ((r + 1) * (r + 1) <= n) begin
            r = r + 1;
        end
        return r;
    endfunction

    function automatic longint saturate(input longint v);
        if (v > sat_max) begin
            return sat_max;
        end else if (v < sat_min) begin
            return sat_min;
        end
        return v;
    endfunction

    task automatic add_row(input quad_root_pkg::din_t rb, input quad_root_pkg::din_t rc,
                           input quad_root_pkg::band_t rband, input int gap);
        longint disc_full;
        longint disc;
        longint b_n;
        longint s;
        // b*b and 4c both carry twice the input fraction bits
        disc_full = longint'(rb) * longint'(rb) - (longint'(rc) <<< (`QR_DIN_POINT + 2));
        disc = saturate(disc_full >>> (2 * `QR_DIN_POINT - `QR_SQRT_POINT));
        b_n = saturate(longint'(rb) >>> (`QR_DIN_POINT - `QR_SQRT_POINT));
        row_b[rows_filled] = rb;
        row_c[rows_filled] = rc;
        row_band[rows_filled] = rband;
        row_gap[rows_filled] = gap;
        exp_error[rows_filled] = (disc < 0);
        s = (disc < 0) ? 0 : isqrt(disc <<< `QR_SQRT_POINT);
        exp_x1[rows_filled] = quad_root_pkg::sqrt_t'((s - b_n) >>> 1);
        exp_x2[rows_filled] = quad_root_pkg::sqrt_t'((-b_n - s) >>> 1);
        total_gap += gap;
        rows_filled++;
    endtask

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= timeout_limit) begin
            $display("timeout after %0d cycles, %0d of %0d results seen",
                     cycles, results, num_rows);
            $display("Test FAILED");
            $finish;
        end
    end

    // outputs are registered on the rising edge, so they are stable here
    always @(negedge clk) begin : compare_outputs
        int idx;
        if (rst_n) begin
            if (fifo_full) begin
                saw_full = 1'b1;
            end
            if (dout_valid || dout_error) begin
                if (expect_q.size() == 0) begin
                    errors++;
                    $display("output strobe with no sample outstanding");
                end else begin
                    idx = expect_q.pop_front();
                    results++;
                    checks += 2;
                    if (dout_error !== exp_error[idx]) begin
                        errors++;
                        $display("Fail dout_error row %0d: got %h, expected %h",
                                 idx, dout_error, exp_error[idx]);
                    end
                    if (band_out !== row_band[idx]) begin
                        errors++;
                        $display("Fail band_out row %0d: got %h, expected %h",
                                 idx, band_out, row_band[idx]);
                    end
                    if (dout_valid && !exp_error[idx]) begin
                        checks += 2;
                        if (x1 !== exp_x1[idx]) begin
                            errors++;
                            $display("Fail x1 row %0d: got %h, expected %h",
                                     idx, x1, exp_x1[idx]);
                        end
                        if (x2 !== exp_x2[idx]) begin
                            errors++;
                            $display("Fail x2 row %0d: got %h, expected %h",
                                     idx, x2, exp_x2[idx]);
                        end
                        last_x1 = exp_x1[idx];
                        last_x2 = exp_x2[idx];
                        have_last = 1'b1;
                    end
                    // an error strobe leaves the previous roots in place
                    if (dout_error && have_last) begin
                        checks += 2;
                        if (x1 !== last_x1) begin
                            errors++;
                            $display("Fail x1 held at row %0d: got %h, expected %h",
                                     idx, x1, last_x1);
                        end
                        if (x2 !== last_x2) begin
                            errors++;
                            $display("Fail x2 held at row %0d: got %h, expected %h",
                                     idx, x2, last_x2);
                        end
                    end
                end
            end
        end
    end

    initial begin
        logic [31:0] rb;
        logic [31:0] rc;
        logic [31:0] rband;
        logic [31:0] rgap;
        int          i;
        int          gap_left;
        rst_n = 1'b0;
        b = '0;
        c = '0;
        din_valid = 1'b0;
        band_in = '0;
        sent = 0;
        results = 0;
        errors = 0;
        checks = 0;
        saw_full = 1'b0;
        have_last = 1'b0;
        rows_filled = 0;
        total_gap = 0;
        lfsr_state = 32'h5ce7_0974;

        // roots 0.5 and 0.25
        add_row(16'shd000, 16'sh0800, 2'd1, 0);
        add_row(16'sh2000, 16'sh1000, 2'd2, 3);
        // zero discriminant, double root at 0.5
        add_row(16'shc000, 16'sh1000, 2'd0, 0);
        // discriminant and b both at the edge of the narrow range
        add_row(16'sh8000, 16'sh8000, 2'd3, 0);
        add_row(16'sh7fff, 16'sh7fff, 2'd1, 2);
        add_row(16'sh1333, 16'shf000, 2'd3, 0);
        // drain before the burst so it starts from an empty FIFO
        add_row(16'sh0100, 16'sh0000, 2'd2, 90);
        for (int k = 0; k < num_burst + num_random; k++) begin
            random_bits(16, rb);
            random_bits(16, rc);
            random_bits(2, rband);
            random_bits(3, rgap);
            add_row(rb[15:0], rc[15:0], rband[1:0], (k < num_burst) ? 0 : int'(rgap));
        end
        timeout_limit = num_rows * (`QR_SQRT_ITER + 3) + total_gap + 100;

        repeat (8) @(posedge clk);
        rst_n <= 1'b1;

        i = 0;
        gap_left = 0;
        while (i < num_rows) begin
            @(posedge clk);
            if (gap_left == 0 && sent - results < max_in_flight) begin
                b <= row_b[i];
                c <= row_c[i];
                band_in <= row_band[i];
                din_valid <= 1'b1;
                expect_q.push_back(i);
                sent++;
                gap_left = row_gap[i];
                i++;
            end else begin
                din_valid <= 1'b0;
                if (gap_left > 0) begin
                    gap_left--;
                end
            end
        end
        @(posedge clk);
        din_valid <= 1'b0;

        while (results < num_rows) begin
            @(posedge clk);
        end
        // room for any stray strobe after the last result
        repeat (20) @(posedge clk);
        checks++;
        if (!saw_full) begin
            errors++;
            $display("fifo_full never rose during the burst");
        end
        errors += quad_root_iterative_inst.checker_inst.assert_failures;

        $display("%0d checks, %0d errors, %0d of %0d results", checks, errors, results,
                 num_rows);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// File: verilog.f
+incdir+include
verilog/quad_root_pkg.sv
verilog/fixed_point_cast.sv
verilog/discriminant_stage.sv
verilog/sample_fifo.sv
verilog/iterative_sqrt.sv
verilog/root_engine.sv
verilog/quad_root_iterative.sv
sim/quad_root_checker.sv
sim/quad_root_tb.sv
